// File: hw/vlsu_pkg.sv
package vlsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;
  // Vector length and element index, vl is 1 to 255
  localparam int unsigned VL_W   = 8;

  //////////////////////////////////////////////////////////////////////
  // Sequencer side

  typedef struct packed {
    logic                     is_store;
    logic [ADDR_W-1:0]        base_addr;
    // Byte stride, two's complement
    logic signed [ADDR_W-1:0] stride;
    logic [VL_W-1:0]          vl;
  } vlsu_req_t;

  typedef struct packed {
    logic [VL_W-1:0] vl;
  } addrgen_job_t;

  typedef struct packed {
    logic [VL_W-1:0]   idx;
    logic [DATA_W-1:0] data;
  } ldu_result_t;

  //////////////////////////////////////////////////////////////////////
  // Memory port channels

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } mem_ar_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } mem_aw_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } mem_w_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              err;
  } mem_r_t;

  typedef struct packed {
    logic err;
  } mem_b_t;

  // Master-driven half of the port
  typedef struct packed {
    mem_ar_t ar;
    logic    ar_valid;
    mem_aw_t aw;
    logic    aw_valid;
    mem_w_t  w;
    logic    w_valid;
    logic    r_ready;
    logic    b_ready;
  } mem_req_t;

  // Slave-driven half of the port
  typedef struct packed {
    logic    ar_ready;
    logic    aw_ready;
    logic    w_ready;
    mem_r_t  r;
    logic    r_valid;
    mem_b_t  b;
    logic    b_valid;
  } mem_resp_t;

endpackage

// File: hw/vlsu_spill_reg.sv
module vlsu_spill_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  // Upstream side
  input  payload_t in_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  // Downstream side
  output payload_t out_o,
  output logic     out_valid_o,
  input  logic     out_ready_i
);

  // Two slots, so ready never depends on the downstream ready
  payload_t   slot_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push;
  logic       pop;

  assign in_ready_o  = (count_q != 2'd2);
  assign out_valid_o = (count_q != 2'd0);
  assign out_o       = slot_q[rd_ptr_q];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push)
        wr_ptr_q <= ~wr_ptr_q;
      if (pop)
        rd_ptr_q <= ~rd_ptr_q;
      case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push)
      slot_q[wr_ptr_q] <= in_i;
  end

endmodule

// File: hw/vlsu_addrgen.sv
module vlsu_addrgen import vlsu_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  // Sequencer
  input  vlsu_req_t    req_i,
  input  logic         req_valid_i,
  output logic         req_ready_o,
  // Read address channel
  output mem_ar_t      ar_o,
  output logic         ar_valid_o,
  input  logic         ar_ready_i,
  // Write address channel
  output mem_aw_t      aw_o,
  output logic         aw_valid_o,
  input  logic         aw_ready_i,
  // Jobs for the load and store units
  output addrgen_job_t ldu_job_o,
  output logic         ldu_job_valid_o,
  input  logic         ldu_job_ready_i,
  output addrgen_job_t stu_job_o,
  output logic         stu_job_valid_o,
  input  logic         stu_job_ready_i
);

  typedef enum logic [1:0] {
    AG_IDLE,
    AG_HANDOFF,
    AG_ISSUE
  } ag_state_e;

  ag_state_e         state_q;
  ag_state_e         state_d;
  vlsu_req_t         req_q;
  logic [ADDR_W-1:0] addr_q;
  logic [VL_W-1:0]   elem_q;
  logic              accept;
  logic              job_fire;
  logic              addr_fire;
  logic              last_elem;

  assign req_ready_o = (state_q == AG_IDLE);
  assign accept      = req_valid_i && req_ready_o;

  //////////////////////////////////////////////////////////////////////
  // Job handoff

  assign ldu_job_o       = '{vl: req_q.vl};
  assign stu_job_o       = '{vl: req_q.vl};
  assign ldu_job_valid_o = (state_q == AG_HANDOFF) && !req_q.is_store;
  assign stu_job_valid_o = (state_q == AG_HANDOFF) && req_q.is_store;

  assign job_fire = (ldu_job_valid_o && ldu_job_ready_i) ||
                    (stu_job_valid_o && stu_job_ready_i);

  //////////////////////////////////////////////////////////////////////
  // Address issue

  // Same running address feeds both channels, is_store picks one
  assign ar_o       = '{addr: addr_q};
  assign aw_o       = '{addr: addr_q};
  assign ar_valid_o = (state_q == AG_ISSUE) && !req_q.is_store;
  assign aw_valid_o = (state_q == AG_ISSUE) && req_q.is_store;

  assign addr_fire = (ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i);
  assign last_elem = (elem_q == req_q.vl - 1'b1);

  always_comb begin
    state_d = state_q;
    case (state_q)
      AG_IDLE: begin
        if (accept)
          state_d = AG_HANDOFF;
      end
      AG_HANDOFF: begin
        if (job_fire)
          state_d = AG_ISSUE;
      end
      AG_ISSUE: begin
        if (addr_fire && last_elem)
          state_d = AG_IDLE;
      end
      default: state_d = AG_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i)
      state_q <= AG_IDLE;
    else
      state_q <= state_d;
  end

  // Instruction copy, element counter and running address
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q  <= req_i;
      addr_q <= req_i.base_addr;
      elem_q <= '0;
    end else if (addr_fire) begin
      // Wraps modulo 2^32, negative strides included
      addr_q <= addr_q + req_q.stride;
      elem_q <= elem_q + 1'b1;
    end
  end

endmodule

// File: hw/vlsu_load_unit.sv
module vlsu_load_unit import vlsu_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  // Job from the address generator
  input  addrgen_job_t job_i,
  input  logic         job_valid_i,
  output logic         job_ready_o,
  // Read data channel
  input  mem_r_t       r_i,
  input  logic         r_valid_i,
  output logic         r_ready_o,
  // Results toward the lanes
  output ldu_result_t  ldu_result_o,
  output logic         ldu_result_valid_o,
  input  logic         ldu_result_ready_i,
  // Completion
  output logic         load_complete_o,
  output logic         load_error_o
);

  logic            busy_q;
  logic [VL_W-1:0] vl_q;
  logic [VL_W-1:0] idx_q;
  logic            err_q;
  logic            complete_q;
  logic            error_q;
  logic            job_fire;
  logic            res_fire;
  logic            last_res;

  assign job_ready_o = !busy_q;
  assign job_fire    = job_valid_i && job_ready_o;

  // Read beat passes straight through, lane stall holds the R channel
  assign ldu_result_valid_o = busy_q && r_valid_i;
  assign r_ready_o          = busy_q && ldu_result_ready_i;
  assign ldu_result_o       = '{idx: idx_q, data: r_i.data};

  assign res_fire = ldu_result_valid_o && ldu_result_ready_i;
  assign last_res = (idx_q == vl_q - 1'b1);

  assign load_complete_o = complete_q;
  assign load_error_o    = error_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q     <= 1'b0;
      err_q      <= 1'b0;
      complete_q <= 1'b0;
      error_q    <= 1'b0;
    end else begin
      complete_q <= res_fire && last_res;
      error_q    <= res_fire && last_res && (err_q || r_i.err);
      if (job_fire) begin
        busy_q <= 1'b1;
        err_q  <= 1'b0;
      end else if (res_fire) begin
        err_q <= err_q || r_i.err;
        if (last_res)
          busy_q <= 1'b0;
      end
    end
  end

  // Element index of the next result
  always_ff @(posedge clk_i) begin
    if (job_fire) begin
      vl_q  <= job_i.vl;
      idx_q <= '0;
    end else if (res_fire) begin
      idx_q <= idx_q + 1'b1;
    end
  end

endmodule

// File: hw/vlsu_store_unit.sv
module vlsu_store_unit import vlsu_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  // Job from the address generator
  input  addrgen_job_t      job_i,
  input  logic              job_valid_i,
  output logic              job_ready_o,
  // Store operands from the lanes
  input  logic [DATA_W-1:0] stu_operand_i,
  input  logic              stu_operand_valid_i,
  output logic              stu_operand_ready_o,
  // Write data channel
  output mem_w_t            w_o,
  output logic              w_valid_o,
  input  logic              w_ready_i,
  // Write response channel
  input  mem_b_t            b_i,
  input  logic              b_valid_i,
  output logic              b_ready_o,
  // Completion
  output logic              store_complete_o,
  output logic              store_error_o
);

  logic            busy_q;
  logic [VL_W-1:0] vl_q;
  logic [VL_W-1:0] sent_q;
  logic [VL_W-1:0] resp_q;
  logic            err_q;
  logic            complete_q;
  logic            error_q;
  logic            job_fire;
  logic            beats_left;
  logic            w_fire;
  logic            b_fire;
  logic            last_resp;

  assign job_ready_o = !busy_q;
  assign job_fire    = job_valid_i && job_ready_o;

  //////////////////////////////////////////////////////////////////////
  // Write beats

  assign beats_left = busy_q && (sent_q != vl_q);

  assign w_o                 = '{data: stu_operand_i, strb: '1};
  assign w_valid_o           = beats_left && stu_operand_valid_i;
  assign stu_operand_ready_o = beats_left && w_ready_i;
  assign w_fire              = w_valid_o && w_ready_i;

  //////////////////////////////////////////////////////////////////////
  // Write responses

  // Responses are counted apart from beats, data may run ahead
  assign b_ready_o = busy_q;
  assign b_fire    = b_valid_i && b_ready_o;
  assign last_resp = (resp_q == vl_q - 1'b1);

  assign store_complete_o = complete_q;
  assign store_error_o    = error_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q     <= 1'b0;
      err_q      <= 1'b0;
      complete_q <= 1'b0;
      error_q    <= 1'b0;
    end else begin
      complete_q <= b_fire && last_resp;
      error_q    <= b_fire && last_resp && (err_q || b_i.err);
      if (job_fire) begin
        busy_q <= 1'b1;
        err_q  <= 1'b0;
      end else if (b_fire) begin
        err_q <= err_q || b_i.err;
        if (last_resp)
          busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (job_fire) begin
      vl_q   <= job_i.vl;
      sent_q <= '0;
      resp_q <= '0;
    end else begin
      if (w_fire)
        sent_q <= sent_q + 1'b1;
      if (b_fire)
        resp_q <= resp_q + 1'b1;
    end
  end

endmodule

// File: hw/vlsu.sv
module vlsu import vlsu_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  // Sequencer
  input  vlsu_req_t         req_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  // Memory port
  output mem_req_t          mem_req_o,
  input  mem_resp_t         mem_resp_i,
  // Store operands
  input  logic [DATA_W-1:0] stu_operand_i,
  input  logic              stu_operand_valid_i,
  output logic              stu_operand_ready_o,
  // Load results
  output ldu_result_t       ldu_result_o,
  output logic              ldu_result_valid_o,
  input  logic              ldu_result_ready_i,
  // Completion
  output logic              load_complete_o,
  output logic              load_error_o,
  output logic              store_complete_o,
  output logic              store_error_o
);

  // Unit side of each channel slice
  mem_ar_t      ar;
  logic         ar_valid, ar_ready;
  mem_aw_t      aw;
  logic         aw_valid, aw_ready;
  mem_w_t       w;
  logic         w_valid, w_ready;
  mem_r_t       r;
  logic         r_valid, r_ready;
  mem_b_t       b;
  logic         b_valid, b_ready;
  // Memory side of each channel slice
  mem_ar_t      mem_ar;
  mem_aw_t      mem_aw;
  mem_w_t       mem_w;
  logic         mem_ar_valid, mem_aw_valid, mem_w_valid;
  logic         mem_r_ready, mem_b_ready;
  // Jobs
  addrgen_job_t ldu_job, stu_job;
  logic         ldu_job_valid, ldu_job_ready;
  logic         stu_job_valid, stu_job_ready;

  assign mem_req_o = '{ar: mem_ar, ar_valid: mem_ar_valid, aw: mem_aw, aw_valid: mem_aw_valid,
                       w: mem_w, w_valid: mem_w_valid, r_ready: mem_r_ready,
                       b_ready: mem_b_ready};

  //////////////////////////////////////////////////////////////////////
  // Channel slices

  vlsu_spill_reg #(.payload_t(mem_ar_t)) i_ar_spill (
    .clk_i, .rst_i, .in_i(ar), .in_valid_i(ar_valid), .in_ready_o(ar_ready),
    .out_o(mem_ar), .out_valid_o(mem_ar_valid), .out_ready_i(mem_resp_i.ar_ready)
  );

  vlsu_spill_reg #(.payload_t(mem_aw_t)) i_aw_spill (
    .clk_i, .rst_i, .in_i(aw), .in_valid_i(aw_valid), .in_ready_o(aw_ready),
    .out_o(mem_aw), .out_valid_o(mem_aw_valid), .out_ready_i(mem_resp_i.aw_ready)
  );

  vlsu_spill_reg #(.payload_t(mem_w_t)) i_w_spill (
    .clk_i, .rst_i, .in_i(w), .in_valid_i(w_valid), .in_ready_o(w_ready),
    .out_o(mem_w), .out_valid_o(mem_w_valid), .out_ready_i(mem_resp_i.w_ready)
  );

  vlsu_spill_reg #(.payload_t(mem_r_t)) i_r_spill (
    .clk_i, .rst_i, .in_i(mem_resp_i.r), .in_valid_i(mem_resp_i.r_valid),
    .in_ready_o(mem_r_ready), .out_o(r), .out_valid_o(r_valid), .out_ready_i(r_ready)
  );

  vlsu_spill_reg #(.payload_t(mem_b_t)) i_b_spill (
    .clk_i, .rst_i, .in_i(mem_resp_i.b), .in_valid_i(mem_resp_i.b_valid),
    .in_ready_o(mem_b_ready), .out_o(b), .out_valid_o(b_valid), .out_ready_i(b_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // Address generator, load unit, store unit

  vlsu_addrgen i_addrgen (
    .clk_i, .rst_i, .req_i, .req_valid_i, .req_ready_o,
    .ar_o(ar), .ar_valid_o(ar_valid), .ar_ready_i(ar_ready),
    .aw_o(aw), .aw_valid_o(aw_valid), .aw_ready_i(aw_ready),
    .ldu_job_o(ldu_job), .ldu_job_valid_o(ldu_job_valid), .ldu_job_ready_i(ldu_job_ready),
    .stu_job_o(stu_job), .stu_job_valid_o(stu_job_valid), .stu_job_ready_i(stu_job_ready)
  );

  vlsu_load_unit i_load_unit (
    .clk_i, .rst_i,
    .job_i(ldu_job), .job_valid_i(ldu_job_valid), .job_ready_o(ldu_job_ready),
    .r_i(r), .r_valid_i(r_valid), .r_ready_o(r_ready),
    .ldu_result_o, .ldu_result_valid_o, .ldu_result_ready_i,
    .load_complete_o, .load_error_o
  );

  vlsu_store_unit i_store_unit (
    .clk_i, .rst_i,
    .job_i(stu_job), .job_valid_i(stu_job_valid), .job_ready_o(stu_job_ready),
    .stu_operand_i, .stu_operand_valid_i, .stu_operand_ready_o,
    .w_o(w), .w_valid_o(w_valid), .w_ready_i(w_ready),
    .b_i(b), .b_valid_i(b_valid), .b_ready_o(b_ready),
    .store_complete_o, .store_error_o
  );

endmodule

// File: test/vlsu_mem_model.sv
module vlsu_mem_model import vlsu_pkg::*; #(
  parameter logic [DATA_W-1:0] FILL_PATTERN = 32'h0,
  parameter logic [ADDR_W-1:0] ERR_LO       = 32'h0,
  parameter logic [ADDR_W-1:0] ERR_HI       = 32'h0,
  parameter int                SEED         = 1
) (
  input  logic      clk_i,
  input  logic      rst_i,
  input  mem_req_t  mem_req_i,
  output mem_resp_t mem_resp_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [DATA_W-1:0] mem [256];
  logic [ADDR_W-1:0] rd_q [$];
  logic [ADDR_W-1:0] aw_q [$];
  logic [DATA_W-1:0] wd_q [$];
  logic              b_err_q [$];
  integer            seed;

  function automatic logic in_window(input logic [ADDR_W-1:0] addr);
    return (addr >= ERR_LO) && (addr <= ERR_HI);
  endfunction

  // Three cycles out of four go ahead
  function automatic logic go();
    return ($random(seed) & 3) != 0;
  endfunction

  initial begin
    seed = SEED;
    for (int n = 0; n < 256; n++)
      mem[n] = ADDR_W'(n * 4) ^ FILL_PATTERN;
  end

  always @(posedge clk_i) begin : serve
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] d;
    if (rst_i) begin
      mem_resp_o <= '0;
      rd_q.delete();
      aw_q.delete();
      wd_q.delete();
      b_err_q.delete();
    end else begin
      if (mem_req_i.ar_valid && mem_resp_o.ar_ready)
        rd_q.push_back(mem_req_i.ar.addr);
      if (mem_req_i.aw_valid && mem_resp_o.aw_ready)
        aw_q.push_back(mem_req_i.aw.addr);
      if (mem_req_i.w_valid && mem_resp_o.w_ready)
        wd_q.push_back(mem_req_i.w.data);
      // Write once address and data are both here
      if (aw_q.size() > 0 && wd_q.size() > 0) begin
        a = aw_q.pop_front();
        d = wd_q.pop_front();
        if (!in_window(a))
          mem[a[9:2]] = d;
        b_err_q.push_back(in_window(a));
      end
      // Reads wait behind pending writes
      if (!mem_resp_o.r_valid || mem_req_i.r_ready) begin
        if (rd_q.size() > 0 && aw_q.size() == 0 && wd_q.size() == 0 &&
            !mem_req_i.aw_valid && go()) begin
          a = rd_q.pop_front();
          mem_resp_o.r.data  <= in_window(a) ? '0 : mem[a[9:2]];
          mem_resp_o.r.err   <= in_window(a);
          mem_resp_o.r_valid <= 1'b1;
        end else begin
          mem_resp_o.r_valid <= 1'b0;
        end
      end
      if (!mem_resp_o.b_valid || mem_req_i.b_ready) begin
        if (b_err_q.size() > 0 && go()) begin
          mem_resp_o.b.err   <= b_err_q.pop_front();
          mem_resp_o.b_valid <= 1'b1;
        end else begin
          mem_resp_o.b_valid <= 1'b0;
        end
      end
      mem_resp_o.ar_ready <= go();
      mem_resp_o.aw_ready <= go();
      mem_resp_o.w_ready  <= go();
    end
  end

endmodule

// File: test/vlsu_tb.sv
module vlsu_tb import vlsu_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [DATA_W-1:0] FILL_PATTERN = 32'hA5C3_0F96;
  localparam logic [ADDR_W-1:0] ERR_LO       = 32'h0000_F000;
  localparam logic [ADDR_W-1:0] ERR_HI       = 32'h0000_F0FF;
  localparam int                TIMEOUT      = 20000;

  typedef struct packed {
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] stride;
    logic [VL_W-1:0]   idx;
  } ld_elem_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } wr_elem_t;

  logic              clk_i = 1'b0;
  logic              rst_i;
  vlsu_req_t         req_i;
  logic              req_valid_i;
  logic              req_ready_o;
  mem_req_t          mem_req;
  mem_resp_t         mem_resp;
  logic [DATA_W-1:0] stu_operand_i = '0;
  logic              stu_operand_valid_i = 1'b0;
  logic              stu_operand_ready_o;
  ldu_result_t       ldu_result_o;
  logic              ldu_result_valid_o;
  logic              ldu_result_ready_i = 1'b0;
  logic              load_complete_o, load_error_o;
  logic              store_complete_o, store_error_o;

  integer            seed = 71687;
  integer            stall_seed = 71687;
  logic              lane_stall = 1'b0;
  logic              timed_out = 1'b0;
  int                errors = 0;
  int                checks = 0;
  int                tests = 0;
  logic [DATA_W-1:0] shadow [256];
  logic [DATA_W-1:0] operands [$];
  ld_elem_t          exp_ld [$];
  wr_elem_t          exp_wr [$];
  logic              exp_ld_err [$];
  logic              exp_st_err [$];
  logic [ADDR_W-1:0] seen_aw [$];
  mem_w_t            seen_w [$];

  vlsu UUT (
    .clk_i, .rst_i, .req_i, .req_valid_i, .req_ready_o,
    .mem_req_o(mem_req), .mem_resp_i(mem_resp),
    .stu_operand_i, .stu_operand_valid_i, .stu_operand_ready_o,
    .ldu_result_o, .ldu_result_valid_o, .ldu_result_ready_i,
    .load_complete_o, .load_error_o, .store_complete_o, .store_error_o
  );

  vlsu_mem_model #(
    .FILL_PATTERN(FILL_PATTERN), .ERR_LO(ERR_LO), .ERR_HI(ERR_HI), .SEED(71687)
  ) i_mem (
    .clk_i, .rst_i, .mem_req_i(mem_req), .mem_resp_o(mem_resp)
  );

  always #10 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Reference model

  function automatic logic [DATA_W-1:0] init_word(input logic [ADDR_W-1:0] addr);
    return {22'd0, addr[9:2], 2'b00} ^ FILL_PATTERN;
  endfunction

  function automatic logic in_window(input logic [ADDR_W-1:0] addr);
    return (addr >= ERR_LO) && (addr <= ERR_HI);
  endfunction

  // Element i sits at base + i * stride
  // Data comes from the shadow copy of memory
  function automatic void ref_elem(input logic [ADDR_W-1:0] base,
                                   input logic [ADDR_W-1:0] stride, input int unsigned i,
                                   output logic [ADDR_W-1:0] addr,
                                   output logic [DATA_W-1:0] data);
    addr = base + stride * ADDR_W'(i);
    data = in_window(addr) ? '0 : shadow[addr[9:2]];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic check_result(input ldu_result_t got, input ldu_result_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: load result idx %0d data %h, expected idx %0d data %h",
               $time, got.idx, got.data, exp.idx, exp.data);
    end
  endtask

  task automatic check_write(input mem_w_t got_w, input logic [ADDR_W-1:0] got_addr,
                             input mem_w_t exp_w, input logic [ADDR_W-1:0] exp_addr);
    checks++;
    if (got_w !== exp_w || got_addr !== exp_addr) begin
      errors++;
      $display("[FAIL] %0t: write %h to %h (strb %b), expected %h to %h",
               $time, got_w.data, got_addr, got_w.strb, exp_w.data, exp_addr);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic note_timeout(input string why);
    timed_out = 1'b1;
    $display("Timeout while %s", why);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Lane side drivers and monitor

  always @(posedge clk_i) begin
    if (stu_operand_valid_i && stu_operand_ready_o)
      void'(operands.pop_front());
    if (operands.size() > 0) begin
      stu_operand_i       <= operands[0];
      stu_operand_valid_i <= 1'b1;
    end else begin
      stu_operand_valid_i <= 1'b0;
    end
    ldu_result_ready_i <= lane_stall ? (($random(stall_seed) & 1) != 0) : 1'b1;
  end

  always @(posedge clk_i) begin : monitor
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] d;
    ld_elem_t          e;
    wr_elem_t          x;
    mem_w_t            w;
    if (!rst_i) begin
      if (mem_req.aw_valid && mem_resp.aw_ready)
        seen_aw.push_back(mem_req.aw.addr);
      if (mem_req.w_valid && mem_resp.w_ready)
        seen_w.push_back(mem_req.w);
      while (seen_aw.size() > 0 && seen_w.size() > 0) begin
        a = seen_aw.pop_front();
        w = seen_w.pop_front();
        if (exp_wr.size() == 0) begin
          errors++;
          $display("Unexpected write of %h to %h at %0t", w.data, a, $time);
        end else begin
          x = exp_wr.pop_front();
          check_write(w, a, '{data: x.data, strb: '1}, x.addr);
          if (!in_window(x.addr))
            shadow[x.addr[9:2]] = x.data;
        end
      end
      if (ldu_result_valid_o && ldu_result_ready_i) begin
        if (exp_ld.size() == 0) begin
          errors++;
          $display("Unexpected load result at %0t", $time);
        end else begin
          e = exp_ld.pop_front();
          ref_elem(e.base, e.stride, e.idx, a, d);
          check_result(ldu_result_o, '{idx: e.idx, data: d});
        end
      end
      if (load_complete_o) begin
        if (exp_ld_err.size() == 0) begin
          errors++;
          $display("Extra load completion pulse at %0t", $time);
        end else begin
          check_bit(load_error_o, exp_ld_err.pop_front(), "load_error_o");
        end
      end
      if (store_complete_o) begin
        if (exp_st_err.size() == 0) begin
          errors++;
          $display("Extra store completion pulse at %0t", $time);
        end else begin
          check_bit(store_error_o, exp_st_err.pop_front(), "store_error_o");
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sequencer side

  task automatic issue(input logic st, input logic [ADDR_W-1:0] base,
                       input logic [ADDR_W-1:0] stride, input int vl);
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] d;
    logic              err;
    int                cycles;
    if (timed_out)
      return;
    err = 1'b0;
    for (int i = 0; i < vl; i++) begin
      ref_elem(base, stride, i, a, d);
      err = err | in_window(a);
      if (st) begin
        d = $random(seed);
        operands.push_back(d);
        exp_wr.push_back('{addr: a, data: d});
      end else begin
        exp_ld.push_back('{base: base, stride: stride, idx: VL_W'(i)});
      end
    end
    if (st)
      exp_st_err.push_back(err);
    else
      exp_ld_err.push_back(err);
    @(posedge clk_i);
    req_i       <= '{is_store: st, base_addr: base, stride: stride, vl: VL_W'(vl)};
    req_valid_i <= 1'b1;
    cycles = 0;
    @(posedge clk_i);
    while (!req_ready_o && cycles < TIMEOUT) begin
      @(posedge clk_i);
      cycles++;
    end
    if (!req_ready_o)
      note_timeout("waiting for req_ready_o");
    req_valid_i <= 1'b0;
  endtask

  // Holds off a store until earlier load results are all compared
  task automatic wait_loads_compared();
    int cycles;
    if (timed_out)
      return;
    cycles = 0;
    while (exp_ld.size() > 0 && cycles < TIMEOUT) begin
      @(posedge clk_i);
      cycles++;
    end
    if (exp_ld.size() > 0)
      note_timeout("waiting for load results");
  endtask

  function automatic logic drained();
    return exp_ld.size() == 0 && exp_wr.size() == 0 && exp_ld_err.size() == 0 &&
           exp_st_err.size() == 0 && operands.size() == 0 && req_ready_o;
  endfunction

  task automatic finish_test(input string name, input int errors_before);
    int cycles;
    if (timed_out)
      return;
    cycles = 0;
    while (!drained() && cycles < TIMEOUT) begin
      @(posedge clk_i);
      cycles++;
    end
    if (!drained()) begin
      note_timeout({"draining test ", name});
    end else begin
      tests++;
      if (errors == errors_before)
        $display("Test %s: ok", name);
      else
        $display("Test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  initial begin
    int               e0;
    logic             st;
    logic [ADDR_W-1:0] stride;
    for (int n = 0; n < 256; n++)
      shadow[n] = init_word(ADDR_W'(n * 4));
    rst_i       = 1'b1;
    req_i       = '0;
    req_valid_i = 1'b0;
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);

    // Idle outputs after reset
    e0 = errors;
    @(posedge clk_i);
    check_bit(req_ready_o, 1'b1, "req_ready_o");
    check_bit(mem_req.ar_valid | mem_req.aw_valid | mem_req.w_valid, 1'b0, "memory valid");
    check_bit(ldu_result_valid_o, 1'b0, "ldu_result_valid_o");
    check_bit(load_complete_o | store_complete_o, 1'b0, "complete pulse");
    check_bit(load_error_o | store_error_o, 1'b0, "error output");
    finish_test("reset state", e0);

    e0 = errors;
    issue(1'b0, 32'h0000_0100, 32'd4, 16);
    finish_test("unit-stride load", e0);

    e0 = errors;
    issue(1'b1, 32'h0000_02F0, 32'hFFFF_FFFC, 12);
    issue(1'b0, 32'h0000_02F0, 32'hFFFF_FFFC, 12);
    finish_test("negative-stride store and read back", e0);

    e0 = errors;
    lane_stall = 1'b1;
    repeat (20) begin
      st = 1'($random(seed) & 1);
      case ($random(seed) & 3)
        0:       stride = 32'hFFFF_FFF8;
        1:       stride = 32'd4;
        2:       stride = 32'd8;
        default: stride = 32'hFFFF_FFFC;
      endcase
      if (st)
        wait_loads_compared();
      issue(st, 32'h0000_1000 + ({$random(seed)} % 256) * 4, stride,
            1 + int'({$random(seed)} % 24));
    end
    finish_test("random instructions with stalls", e0);
    lane_stall = 1'b0;

    e0 = errors;
    issue(1'b1, 32'h0000_0400, 32'd8, 10);
    issue(1'b0, 32'h0000_0400, 32'd8, 10);
    finish_test("load behind store", e0);

    e0 = errors;
    issue(1'b0, 32'h0000_F000, 32'd4, 8);
    issue(1'b1, 32'h0000_F0F0, 32'd4, 8);
    issue(1'b0, 32'h0000_EFF8, 32'd4, 4);
    issue(1'b0, 32'h0000_3000, 32'd4, 4);
    issue(1'b1, 32'h0000_3100, 32'd4, 4);
    finish_test("error window", e0);

    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0 && !timed_out)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// File: files.f
hw/vlsu_pkg.sv
hw/vlsu_spill_reg.sv
hw/vlsu_addrgen.sv
hw/vlsu_load_unit.sv
hw/vlsu_store_unit.sv
hw/vlsu.sv
test/vlsu_mem_model.sv
test/vlsu_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = vlsu_tb
FILELIST = files.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
